//--- memPkg.sv
package memPkg;

    localparam int nickWidth = 4; // load-store buffer tag width.

    typedef enum logic {
        memLoad,
        memStore
    } memOp;

    // access length, 1, 2 or 4 bytes.
    typedef enum logic [1:0] {
        lenByte,
        lenHalf,
        lenWord
    } memLen;

    typedef struct packed {
        memOp        op;
        memLen       len;
        logic [31:0] addr;
        logic [31:0] data; // store data, low bytes first.
    } memReq;

    typedef struct packed {
        memReq                request;
        logic [nickWidth-1:0] nick;
    } lsuReq;

    typedef struct packed {
        logic [31:0]          data;
        logic [nickWidth-1:0] nick;
    } lsuResp;

    typedef enum logic [1:0] {
        ctrlIdle,
        ctrlData,   // byte-serial access for the data port.
        ctrlFetch,  // byte-serial access for the fetch port.
        ctrlFinish  // last ram read of a load.
    } ctrlState;

endpackage

//--- byteRam.sv
`timescale 1ns/1ps

module byteRam #(
    parameter int ramAddrBits = 10
) (
    input  logic                   clk,
    input  logic [ramAddrBits-1:0] addr,
    input  logic                   we,
    input  logic [7:0]             wdata,
    output logic [7:0]             rdata
);

    logic [7:0] mem [2**ramAddrBits];

    initial begin
        foreach (mem[i]) begin
            mem[i] = 8'h00;
        end
    end

    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // old data on a same-cycle write.
    end

endmodule

//--- dataPort.sv
`timescale 1ns/1ps

module dataPort (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,

    input  logic               lsuValid,
    input  memPkg::lsuReq      req,
    output logic               lsuReady,
    output logic               lsuDone,
    output memPkg::lsuResp     resp,

    output logic               memEn,
    output memPkg::memReq      memRequest,
    input  logic               memWait,
    input  logic               memDone,
    input  logic [31:0]        memData
);

    memPkg::lsuReq entry;
    logic          occupied;
    logic          served;
    logic          accept;

    assign accept     = lsuValid && lsuReady;
    assign lsuReady   = !occupied;
    assign memRequest = entry.request;

    // request the controller until it has answered; drop while it is busy.
    assign memEn = occupied && !served && !memDone && !memWait;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            served   <= 1'b0;
            lsuDone  <= 1'b0;
        end else if (rdy) begin
            lsuDone <= memDone;
            if (accept) begin
                occupied <= 1'b1;
                served   <= 1'b0;
            end else if (lsuDone) begin
                occupied <= 1'b0; // free one cycle after the response.
            end
            if (memDone) begin
                served <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (accept) begin
                entry <= req;
            end
            if (memDone) begin
                resp.nick <= entry.nick;
                if (entry.request.op == memPkg::memStore) begin
                    resp.data <= '0; // stores carry no data back.
                end else begin
                    resp.data <= memData;
                end
            end
        end
    end

endmodule

//--- fetchPort.sv
`timescale 1ns/1ps

module fetchPort (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,

    input  logic          fetchValid,
    input  logic [31:0]   fetchPc,
    output logic          fetchReady,
    output logic          fetchDone,
    output logic [31:0]   fetchInstr,

    output logic          memEn,
    output memPkg::memReq memRequest,
    input  logic          memWait,
    input  logic          memDone,
    input  logic [31:0]   memData
);

    logic [31:0] pc;
    logic        occupied;
    logic        served;
    logic        accept;

    assign accept     = fetchValid && fetchReady;
    assign fetchReady = !occupied;
    assign memEn      = occupied && !served && !memDone && !memWait;

    // every fetch is a word load.
    always_comb begin
        memRequest.op   = memPkg::memLoad;
        memRequest.len  = memPkg::lenWord;
        memRequest.addr = pc;
        memRequest.data = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            served    <= 1'b0;
            fetchDone <= 1'b0;
        end else if (rdy) begin
            fetchDone <= memDone;
            if (accept) begin
                occupied <= 1'b1;
                served   <= 1'b0;
            end else if (fetchDone) begin
                occupied <= 1'b0;
            end
            if (memDone) begin
                served <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (accept) begin
                pc <= fetchPc;
            end
            if (memDone) begin
                fetchInstr <= memData;
            end
        end
    end

endmodule

//--- memCtrl.sv
`timescale 1ns/1ps

module memCtrl #(
    parameter int ramAddrBits = 10
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,

    input  logic                   dataEn,
    input  memPkg::memReq          dataReq,
    output logic                   dataWait,
    output logic                   dataDone,
    output logic [31:0]            dataRdata,

    input  logic                   fetchEn,
    input  memPkg::memReq          fetchReq,
    output logic                   fetchWait,
    output logic                   fetchDone,
    output logic [31:0]            fetchRdata,

    output logic [ramAddrBits-1:0] ramAddr,
    output logic                   ramWe,
    output logic [7:0]             ramWdata,
    input  logic [7:0]             ramRdata
);

    memPkg::ctrlState       state;
    memPkg::memReq          cur;
    logic                   lastFetch; // port served last, also the current owner.
    logic [1:0]             cnt;
    logic [1:0]             lastCnt;
    logic                   busy;
    logic                   grantData;
    logic                   grantFetch;
    logic                   capture;
    logic [1:0]             lane;
    logic [31:0]            loadBuf;
    logic [31:0]            loadWord;
    logic [31:0]            rdataReg;
    logic [ramAddrBits-1:0] byteAddr;
    logic [ramAddrBits-1:0] heldAddr;

    assign busy      = (state == memPkg::ctrlData) || (state == memPkg::ctrlFetch);
    assign dataWait  = state != memPkg::ctrlIdle;
    assign fetchWait = state != memPkg::ctrlIdle;

    // round robin when both ask.
    assign grantFetch = fetchEn && (!dataEn || !lastFetch);
    assign grantData  = dataEn && !grantFetch;

    always_comb begin
        case (cur.len)
            memPkg::lenByte: lastCnt = 2'd0;
            memPkg::lenHalf: lastCnt = 2'd1;
            default:         lastCnt = 2'd3;
        endcase
    end

    assign byteAddr = cur.addr[ramAddrBits-1:0] + ramAddrBits'(cnt);

    // while frozen keep the last address so the pending read byte survives.
    assign ramAddr  = rdy ? byteAddr : heldAddr;
    assign ramWe    = rdy && busy && (cur.op == memPkg::memStore);
    assign ramWdata = cur.data[{cnt, 3'b000} +: 8];

    // read data trails the address by one cycle.
    assign capture = (busy && cur.op == memPkg::memLoad && cnt != 2'd0)
                     || (state == memPkg::ctrlFinish);
    assign lane    = (state == memPkg::ctrlFinish) ? cnt : cnt - 2'd1;

    always_comb begin
        loadWord = loadBuf;
        loadWord[{lane, 3'b000} +: 8] = ramRdata;
    end

    assign dataRdata  = rdataReg;
    assign fetchRdata = rdataReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= memPkg::ctrlIdle;
            lastFetch <= 1'b0;
            cnt       <= 2'd0;
            dataDone  <= 1'b0;
            fetchDone <= 1'b0;
        end else if (rdy) begin
            dataDone  <= 1'b0;
            fetchDone <= 1'b0;
            case (state)
                memPkg::ctrlIdle: begin
                    cnt <= 2'd0;
                    if (grantFetch) begin
                        state     <= memPkg::ctrlFetch;
                        lastFetch <= 1'b1;
                    end else if (grantData) begin
                        state     <= memPkg::ctrlData;
                        lastFetch <= 1'b0;
                    end
                end
                memPkg::ctrlData, memPkg::ctrlFetch: begin
                    if (cnt != lastCnt) begin
                        cnt <= cnt + 2'd1;
                    end else if (cur.op == memPkg::memStore) begin
                        state     <= memPkg::ctrlIdle; // last byte written.
                        dataDone  <= !lastFetch;
                        fetchDone <= lastFetch;
                    end else begin
                        state <= memPkg::ctrlFinish;
                    end
                end
                memPkg::ctrlFinish: begin
                    state     <= memPkg::ctrlIdle;
                    dataDone  <= !lastFetch;
                    fetchDone <= lastFetch;
                end
                default: state <= memPkg::ctrlIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            heldAddr <= byteAddr;
            if (state == memPkg::ctrlIdle && (grantFetch || grantData)) begin
                cur     <= grantFetch ? fetchReq : dataReq;
                loadBuf <= '0; // upper bytes stay zero for short loads.
            end else if (capture) begin
                loadBuf <= loadWord;
            end
            if (state == memPkg::ctrlFinish) begin
                rdataReg <= loadWord;
            end
        end
    end

endmodule

//--- memSystem.sv
`timescale 1ns/1ps

module memSystem #(
    parameter int ramAddrBits = 10
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           rdy,

    input  logic           lsuValid,
    input  memPkg::lsuReq  req,
    output logic           lsuReady,
    output logic           lsuDone,
    output memPkg::lsuResp resp,

    input  logic           fetchValid,
    input  logic [31:0]    fetchPc,
    output logic           fetchReady,
    output logic           fetchDone,
    output logic [31:0]    fetchInstr
);

    logic                   dataEn;
    memPkg::memReq          dataReq;
    logic                   dataWait;
    logic                   ctrlDataDone;
    logic [31:0]            dataRdata;

    logic                   fetchEn;
    memPkg::memReq          fetchReq;
    logic                   fetchWait;
    logic                   ctrlFetchDone;
    logic [31:0]            fetchRdata;

    logic [ramAddrBits-1:0] ramAddr;
    logic                   ramWe;
    logic [7:0]             ramWdata;
    logic [7:0]             ramRdata;

    dataPort dataPortInst (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .lsuValid   (lsuValid),
        .req        (req),
        .lsuReady   (lsuReady),
        .lsuDone    (lsuDone),
        .resp       (resp),
        .memEn      (dataEn),
        .memRequest (dataReq),
        .memWait    (dataWait),
        .memDone    (ctrlDataDone),
        .memData    (dataRdata)
    );

    fetchPort fetchPortInst (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchReady (fetchReady),
        .fetchDone  (fetchDone),
        .fetchInstr (fetchInstr),
        .memEn      (fetchEn),
        .memRequest (fetchReq),
        .memWait    (fetchWait),
        .memDone    (ctrlFetchDone),
        .memData    (fetchRdata)
    );

    memCtrl #(
        .ramAddrBits (ramAddrBits)
    ) memCtrlInst (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .dataEn     (dataEn),
        .dataReq    (dataReq),
        .dataWait   (dataWait),
        .dataDone   (ctrlDataDone),
        .dataRdata  (dataRdata),
        .fetchEn    (fetchEn),
        .fetchReq   (fetchReq),
        .fetchWait  (fetchWait),
        .fetchDone  (ctrlFetchDone),
        .fetchRdata (fetchRdata),
        .ramAddr    (ramAddr),
        .ramWe      (ramWe),
        .ramWdata   (ramWdata),
        .ramRdata   (ramRdata)
    );

    byteRam #(
        .ramAddrBits (ramAddrBits)
    ) byteRamInst (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

//--- tbMemSystem.sv
`timescale 1ns/1ps

module tbMemSystem;

    localparam int timeoutCycles = 4000; // about seven times the full run.

    logic           clk;
    logic           rst;
    logic           rdy;
    logic           lsuValid;
    memPkg::lsuReq  req;
    logic           lsuReady;
    logic           lsuDone;
    memPkg::lsuResp resp;
    logic           fetchValid;
    logic [31:0]    fetchPc;
    logic           fetchReady;
    logic           fetchDone;
    logic [31:0]    fetchInstr;
    logic [7:0]     refMem [1024]; // mirrors every store.
    logic [31:0]    lcgState;
    int             errorCount;
    int             cycleCount = 0;

    memSystem #(.ramAddrBits(10)) uut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout after %0d cycles, a request never completed", cycleCount);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int byteCount(input memPkg::memLen len);
        case (len)
            memPkg::lenByte: return 1;
            memPkg::lenHalf: return 2;
            default:         return 4;
        endcase
    endfunction

    // little-endian, zero-extended, addresses wrap at 1024.
    function automatic logic [31:0] modelLoad(input logic [31:0] addr, input memPkg::memLen len);
        logic [31:0] value;
        logic [9:0]  a;
        int          i;
        value = '0;
        for (i = 0; i < byteCount(len); i++) begin
            a = addr[9:0] + 10'(i);
            value[8*i +: 8] = refMem[a];
        end
        return value;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
        errorCount++;
    endtask

    task automatic reportFailure(input string what);
        $display("error at %0t: %s", $time, what);
        errorCount++;
    endtask

    task automatic startData(input memPkg::memOp op, input memPkg::memLen len,
                             input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] nick);
        while (lsuReady !== 1'b1) @(negedge clk);
        req.request.op   = op;
        req.request.len  = len;
        req.request.addr = addr;
        req.request.data = data;
        req.nick         = nick;
        lsuValid         = 1'b1;
        @(negedge clk);
        lsuValid = 1'b0;
        if (lsuReady !== 1'b0) begin
            reportFailure("lsuReady stayed high after the request was accepted");
        end
    endtask

    task automatic waitData(output memPkg::lsuResp got);
        while (lsuDone !== 1'b1) @(negedge clk);
        got = resp;
        @(negedge clk);
        if (lsuReady !== 1'b1) begin
            reportFailure("lsuReady did not return high after lsuDone");
        end
    endtask

    task automatic dataAccess(input memPkg::memOp op, input memPkg::memLen len,
                              input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] nick);
        memPkg::lsuResp got;
        logic [31:0]    expected;
        logic [9:0]     a;
        int             i;
        expected = '0; // stores answer with zero.
        if (op == memPkg::memStore) begin
            for (i = 0; i < byteCount(len); i++) begin
                a = addr[9:0] + 10'(i);
                refMem[a] = data[8*i +: 8];
            end
        end else begin
            expected = modelLoad(addr, len);
        end
        startData(op, len, addr, data, nick);
        waitData(got);
        if (got.data !== expected) begin
            reportMismatch("resp.data", expected, got.data);
        end
        if (got.nick !== nick) begin
            reportMismatch("resp.nick", 32'(nick), 32'(got.nick));
        end
    endtask

    task automatic fetchAccess(input logic [31:0] pc);
        while (fetchReady !== 1'b1) @(negedge clk);
        fetchPc    = pc;
        fetchValid = 1'b1;
        @(negedge clk);
        fetchValid = 1'b0;
        if (fetchReady !== 1'b0) begin
            reportFailure("fetchReady stayed high after the fetch was accepted");
        end
        while (fetchDone !== 1'b1) @(negedge clk);
        if (fetchInstr !== modelLoad(pc, memPkg::lenWord)) begin
            reportMismatch("fetchInstr", modelLoad(pc, memPkg::lenWord), fetchInstr);
        end
        @(negedge clk);
        if (fetchReady !== 1'b1) begin
            reportFailure("fetchReady did not return high after fetchDone");
        end
    endtask

    task automatic testStoreLoad();
        dataAccess(memPkg::memStore, memPkg::lenWord, 32'h40, lcgNext(), 4'h3);
        dataAccess(memPkg::memLoad, memPkg::lenWord, 32'h40, 32'h0, 4'h5);
        fetchAccess(32'h40);
    endtask

    task automatic testLengths();
        dataAccess(memPkg::memStore, memPkg::lenWord, 32'h100, 32'h8badf00d, 4'h1);
        dataAccess(memPkg::memLoad, memPkg::lenByte, 32'h102, 32'h0, 4'h2);
        dataAccess(memPkg::memLoad, memPkg::lenHalf, 32'h101, 32'h0, 4'h4);
        dataAccess(memPkg::memStore, memPkg::lenByte, 32'h101, 32'hffffff5a, 4'h6);
        dataAccess(memPkg::memLoad, memPkg::lenWord, 32'h100, 32'h0, 4'h8);
        dataAccess(memPkg::memStore, memPkg::lenHalf, 32'h3ff, 32'h1234c3e1, 4'ha);
        dataAccess(memPkg::memLoad, memPkg::lenWord, 32'h3fe, 32'h0, 4'hb); // wraps to 0.
    endtask

    task automatic testReadyTags();
        int n;
        for (n = 0; n < 4; n++) begin
            dataAccess(memPkg::memLoad, memPkg::lenHalf, 32'h100 + 32'(n), 32'h0, 4'(n + 9));
        end
    endtask

    task automatic testFreeze();
        memPkg::lsuResp got;
        startData(memPkg::memLoad, memPkg::lenWord, 32'h100, 32'h0, 4'h7);
        repeat (2) @(negedge clk);
        rdy = 1'b0;
        repeat (10) begin
            @(negedge clk);
            if (lsuDone !== 1'b0) begin
                reportFailure("lsuDone appeared while rdy was low");
            end
        end
        rdy = 1'b1;
        waitData(got);
        if (got.data !== modelLoad(32'h100, memPkg::lenWord)) begin
            reportMismatch("resp.data", modelLoad(32'h100, memPkg::lenWord), got.data);
        end
    endtask

    task automatic testContention(input logic [31:0] addr, input logic [31:0] pc);
        logic        dataSeen;
        logic        fetchSeen;
        logic [31:0] gotData;
        logic [31:0] gotInstr;
        dataSeen  = 1'b0;
        fetchSeen = 1'b0;
        while (lsuReady !== 1'b1 || fetchReady !== 1'b1) @(negedge clk);
        req.request.op   = memPkg::memLoad;
        req.request.len  = memPkg::lenWord;
        req.request.addr = addr;
        req.nick         = 4'he;
        fetchPc          = pc;
        lsuValid         = 1'b1;
        fetchValid       = 1'b1;
        @(negedge clk);
        lsuValid   = 1'b0;
        fetchValid = 1'b0;
        while (!(dataSeen && fetchSeen)) begin
            @(negedge clk);
            if (lsuDone === 1'b1) begin
                dataSeen = 1'b1;
                gotData  = resp.data;
            end
            if (fetchDone === 1'b1) begin
                fetchSeen = 1'b1;
                gotInstr  = fetchInstr;
            end
        end
        if (gotData !== modelLoad(addr, memPkg::lenWord)) begin
            reportMismatch("resp.data", modelLoad(addr, memPkg::lenWord), gotData);
        end
        if (gotInstr !== modelLoad(pc, memPkg::lenWord)) begin
            reportMismatch("fetchInstr", modelLoad(pc, memPkg::lenWord), gotInstr);
        end
    endtask

    task automatic testRandom();
        logic [31:0]   r;
        memPkg::memLen len;
        int            n;
        for (n = 0; n < 40; n++) begin
            r = lcgNext();
            case ((r >> 20) % 32'd3)
                32'd0:   len = memPkg::lenByte;
                32'd1:   len = memPkg::lenHalf;
                default: len = memPkg::lenWord;
            endcase
            dataAccess(r[31] ? memPkg::memStore : memPkg::memLoad, len,
                       {22'd0, r[17:8]}, lcgNext(), 4'(n));
        end
    endtask

    initial begin
        foreach (refMem[i]) begin
            refMem[i] = 8'h00;
        end
        lcgState   = 32'd48151;
        errorCount = 0;
        clk        = 1'b0;
        rst        = 1'b1;
        rdy        = 1'b1;
        lsuValid   = 1'b0;
        req        = '0;
        fetchValid = 1'b0;
        fetchPc    = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        testStoreLoad();
        testLengths();
        testReadyTags();
        testFreeze();
        testContention(32'h40, 32'h100);
        fetchAccess(32'h100);
        testContention(32'h100, 32'h40); // other port wins this time.
        testRandom();
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- compile.f
memPkg.sv
byteRam.sv
dataPort.sv
fetchPort.sv
memCtrl.sv
memSystem.sv
tbMemSystem.sv

//--- Makefile
TOP = tbMemSystem

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module memSystem -f compile.f

sim:
	verilator --binary --timing --top-module $(TOP) -f compile.f -o simv
	./obj_dir/simv | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
